/* logic/cpu_pkg.sv */
package cpu_pkg;

    // register and bus data width
    parameter int data_width = 32;

    // bus address width matching the immediate field
    parameter int address_width = 16;

    // register and flag index width
    parameter int reg_index_width = 3;

    // instruction opcodes held in the low six bits of the word
    typedef enum logic [5:0] {
        load_low  = 6'd0,
        load_high = 6'd1,
        add       = 6'd2,
        sub       = 6'd3,
        and_op    = 6'd4,
        or_op     = 6'd5,
        xor_op    = 6'd6,
        store     = 6'd7,
        set_eq    = 6'd8,
        set_lt    = 6'd9,
        branch    = 6'd10,
        jump      = 6'd11
    } opcode_t;

    // phase sequence of the control unit
    typedef enum logic [1:0] {
        state_fetch   = 2'd0,
        state_execute = 2'd1,
        state_store   = 2'd2
    } cpu_state_t;

endpackage

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [cpu_pkg::reg_index_width-1:0] read_index_a,
    input  logic [cpu_pkg::reg_index_width-1:0] read_index_b,
    input  logic [cpu_pkg::reg_index_width-1:0] write_index,
    input  logic                                write_enable,
    input  logic [cpu_pkg::data_width-1:0]      write_data,
    output logic [cpu_pkg::data_width-1:0]      read_data_a,
    output logic [cpu_pkg::data_width-1:0]      read_data_b
);

    localparam int depth = 1 << cpu_pkg::reg_index_width;

    logic [cpu_pkg::data_width-1:0] registers [depth];

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < depth; i++)
            begin
                registers[i] <= '0;
            end
        end
        else if (write_enable)
        begin
            registers[write_index] <= write_data;
        end
    end

    // combinational reads so an instruction sees the values before its own write
    assign read_data_a = registers[read_index_a];
    assign read_data_b = registers[read_index_b];

endmodule

/* logic/flag_file.sv */
`timescale 1ns/1ps

module flag_file (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [cpu_pkg::reg_index_width-1:0] read_index_a,
    input  logic [cpu_pkg::reg_index_width-1:0] read_index_b,
    input  logic [cpu_pkg::reg_index_width-1:0] write_index,
    input  logic                                write_enable,
    input  logic                                write_data,
    output logic                                read_flag_a,
    output logic                                read_flag_b
);

    logic [(1 << cpu_pkg::reg_index_width)-1:0] flags;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            flags <= '0;
        end
        else if (write_enable)
        begin
            flags[write_index] <= write_data;
        end
    end

    assign read_flag_a = flags[read_index_a];
    assign read_flag_b = flags[read_index_b];

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::opcode_t                opcode,
    input  logic                            half_select,
    input  logic [15:0]                     immediate,
    input  logic [cpu_pkg::data_width-1:0]  operand_a,
    input  logic [cpu_pkg::data_width-1:0]  operand_b,
    input  logic                            flag_a,
    output logic [cpu_pkg::data_width-1:0]  reg_result,
    output logic                            reg_write,
    output logic                            flag_result,
    output logic                            flag_write,
    output logic                            take_branch
);

    localparam int top_bit = cpu_pkg::data_width - 1;

    always_comb
    begin
        reg_result  = '0;
        reg_write   = 1'b0;
        flag_result = 1'b0;
        flag_write  = 1'b0;
        take_branch = 1'b0;
        case (opcode)
            // operand_b holds the destination register for the loads
            cpu_pkg::load_low:
            begin
                reg_result = {operand_b[top_bit:16], immediate};
                reg_write  = 1'b1;
            end
            cpu_pkg::load_high:
            begin
                reg_result = {immediate, operand_b[15:0]};
                reg_write  = 1'b1;
            end
            cpu_pkg::add:
            begin
                reg_result = operand_a + operand_b;
                reg_write  = 1'b1;
            end
            cpu_pkg::sub:
            begin
                reg_result = operand_a - operand_b;
                reg_write  = 1'b1;
            end
            cpu_pkg::and_op:
            begin
                reg_result = operand_a & operand_b;
                reg_write  = 1'b1;
            end
            cpu_pkg::or_op:
            begin
                reg_result = operand_a | operand_b;
                reg_write  = 1'b1;
            end
            cpu_pkg::xor_op:
            begin
                reg_result = operand_a ^ operand_b;
                reg_write  = 1'b1;
            end
            cpu_pkg::set_eq:
            begin
                flag_result = (operand_a == operand_b);
                flag_write  = 1'b1;
            end
            cpu_pkg::set_lt:
            begin
                // half-select bit picks a signed compare
                if (half_select)
                    flag_result = ($signed(operand_a) < $signed(operand_b));
                else
                    flag_result = (operand_a < operand_b);
                flag_write = 1'b1;
            end
            cpu_pkg::branch:
            begin
                take_branch = flag_a;
            end
            cpu_pkg::jump:
            begin
                take_branch = 1'b1;
            end
            default:
            begin
                reg_write = 1'b0;
            end
        endcase
    end

endmodule

/* logic/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control #(
    parameter logic [cpu_pkg::address_width-1:0] reset_vector = '0
) (
    input  logic                                 clock,
    input  logic                                 reset,
    output logic                                 wb_cyc,
    output logic                                 wb_stb,
    output logic                                 wb_we,
    output logic [cpu_pkg::address_width-1:0]    wb_adr,
    output logic [cpu_pkg::data_width-1:0]       wb_dat_w,
    input  logic [cpu_pkg::data_width-1:0]       wb_dat_r,
    input  logic                                 wb_ack,
    output cpu_pkg::opcode_t                     opcode,
    output logic                                 half_select,
    output logic [cpu_pkg::address_width-1:0]    immediate,
    output logic [cpu_pkg::reg_index_width-1:0]  src_a,
    output logic [cpu_pkg::reg_index_width-1:0]  src_b,
    output logic [cpu_pkg::reg_index_width-1:0]  dest,
    input  logic [cpu_pkg::data_width-1:0]       store_data,
    input  logic                                 take_branch,
    output logic                                 execute_phase
);

    cpu_pkg::cpu_state_t                state;
    logic [cpu_pkg::address_width-1:0]  pc;
    logic [cpu_pkg::data_width-1:0]     instruction;
    logic                               is_load;

    // instruction field decode
    assign opcode      = cpu_pkg::opcode_t'(instruction[5:0]);
    assign src_a       = instruction[8:6];
    assign dest        = instruction[14:12];
    assign half_select = instruction[15];
    assign immediate   = instruction[31:16];

    // loads read back their own destination so the other half is kept
    assign is_load = (opcode == cpu_pkg::load_low) || (opcode == cpu_pkg::load_high);
    assign src_b   = is_load ? dest : instruction[11:9];

    assign execute_phase = (state == cpu_pkg::state_execute);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state  <= cpu_pkg::state_fetch;
            pc     <= reset_vector;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end
        else
        begin
            case (state)
                cpu_pkg::state_fetch:
                begin
                    if (!wb_cyc)
                    begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= 1'b0;
                    end
                    else if (wb_ack)
                    begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        state  <= cpu_pkg::state_execute;
                    end
                end
                cpu_pkg::state_execute:
                begin
                    if (opcode == cpu_pkg::store)
                        state <= cpu_pkg::state_store;
                    else
                    begin
                        state <= cpu_pkg::state_fetch;
                        pc    <= take_branch ? immediate : pc + 1'b1;
                    end
                end
                cpu_pkg::state_store:
                begin
                    if (!wb_cyc)
                    begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= 1'b1;
                    end
                    else if (wb_ack)
                    begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                        pc     <= pc + 1'b1;
                        state  <= cpu_pkg::state_fetch;
                    end
                end
                default:
                begin
                    state <= cpu_pkg::state_fetch;
                end
            endcase
        end
    end

    // bus payload is captured when a request starts and held until ack
    always_ff @(posedge clock)
    begin
        if (state == cpu_pkg::state_fetch && !wb_cyc)
            wb_adr <= pc;
        if (state == cpu_pkg::state_store && !wb_cyc)
        begin
            wb_adr   <= immediate;
            wb_dat_w <= store_data;
        end
        if (state == cpu_pkg::state_fetch && wb_cyc && wb_ack)
            instruction <= wb_dat_r;
    end

endmodule

/* logic/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
    parameter logic [cpu_pkg::address_width-1:0] reset_vector = '0
) (
    input  logic                               clock,
    input  logic                               reset,
    output logic                               wb_cyc,
    output logic                               wb_stb,
    output logic                               wb_we,
    output logic [cpu_pkg::address_width-1:0]  wb_adr,
    output logic [cpu_pkg::data_width-1:0]     wb_dat_w,
    input  logic [cpu_pkg::data_width-1:0]     wb_dat_r,
    input  logic                               wb_ack
);

    cpu_pkg::opcode_t                       opcode;
    logic                                   half_select;
    logic [cpu_pkg::address_width-1:0]      immediate;
    logic [cpu_pkg::reg_index_width-1:0]    src_a;
    logic [cpu_pkg::reg_index_width-1:0]    src_b;
    logic [cpu_pkg::reg_index_width-1:0]    dest;
    logic [cpu_pkg::data_width-1:0]         reg_a;
    logic [cpu_pkg::data_width-1:0]         reg_b;
    logic                                   flag_a;
    logic [cpu_pkg::data_width-1:0]         reg_result;
    logic                                   reg_write;
    logic                                   flag_result;
    logic                                   flag_write;
    logic                                   take_branch;
    logic                                   execute_phase;

    cpu_control #(
        .reset_vector (reset_vector)
    ) i_cpu_control (
        .clock         (clock),
        .reset         (reset),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .opcode        (opcode),
        .half_select   (half_select),
        .immediate     (immediate),
        .src_a         (src_a),
        .src_b         (src_b),
        .dest          (dest),
        .store_data    (reg_a),
        .take_branch   (take_branch),
        .execute_phase (execute_phase)
    );

    register_file i_register_file (
        .clock        (clock),
        .reset        (reset),
        .read_index_a (src_a),
        .read_index_b (src_b),
        .write_index  (dest),
        .write_enable (execute_phase & reg_write),
        .write_data   (reg_result),
        .read_data_a  (reg_a),
        .read_data_b  (reg_b)
    );

    // flag port b has no consumer in this instruction set
    flag_file i_flag_file (
        .clock        (clock),
        .reset        (reset),
        .read_index_a (src_a),
        .read_index_b (src_b),
        .write_index  (dest),
        .write_enable (execute_phase & flag_write),
        .write_data   (flag_result),
        .read_flag_a  (flag_a),
        .read_flag_b  ()
    );

    alu i_alu (
        .opcode      (opcode),
        .half_select (half_select),
        .immediate   (immediate),
        .operand_a   (reg_a),
        .operand_b   (reg_b),
        .flag_a      (flag_a),
        .reg_result  (reg_result),
        .reg_write   (reg_write),
        .flag_result (flag_result),
        .flag_write  (flag_write),
        .take_branch (take_branch)
    );

endmodule

/* tb/cpu_assertions.sv */
`timescale 1ns/1ps

module cpu_assertions #(
    parameter logic [cpu_pkg::address_width-1:0] reset_vector = '0
) (
    input logic                               clock,
    input logic                               reset,
    input logic                               wb_cyc,
    input logic                               wb_stb,
    input logic                               wb_we,
    input logic [cpu_pkg::address_width-1:0]  wb_adr,
    input logic [cpu_pkg::data_width-1:0]     wb_dat_w,
    input logic [cpu_pkg::data_width-1:0]     wb_dat_r,
    input logic                               wb_ack
);

    int failure_count = 0;

    // opcodes after which the next fetch is not simply pc + 1
    function automatic logic changes_flow(input logic [5:0] op);
        return (op == cpu_pkg::store) || (op == cpu_pkg::branch) || (op == cpu_pkg::jump);
    endfunction

    property sequential_fetch;
        logic [cpu_pkg::address_width-1:0] fetch_address;
        @(posedge clock) disable iff (reset)
        (wb_stb && !wb_we && wb_ack && !changes_flow(wb_dat_r[5:0]), fetch_address = wb_adr)
        |=> !wb_stb ##1 !wb_stb ##1 (wb_stb && !wb_we && wb_adr == fetch_address + 1'b1);
    endproperty

    // execute takes one cycle, so the target fetch starts three edges after the ack
    property jump_target_fetch;
        logic [cpu_pkg::address_width-1:0] target;
        @(posedge clock) disable iff (reset)
        (wb_stb && !wb_we && wb_ack && wb_dat_r[5:0] == cpu_pkg::jump,
            target = wb_dat_r[31:16])
        |=> !wb_stb ##1 !wb_stb ##1 (wb_stb && !wb_we && wb_adr == target);
    endproperty

    quiet_in_reset: assert property (@(posedge clock) $past(reset) |-> !wb_cyc && !wb_stb)
    else
    begin
        failure_count++;
        $error("bus cycle active during reset or in the cycle after it");
    end

    first_fetch: assert property (@(posedge clock)
        $fell(reset) |=> wb_cyc && wb_stb && !wb_we && wb_adr == reset_vector)
    else
    begin
        failure_count++;
        $error("first request after reset is not a read of the reset vector");
    end

    stb_needs_cyc: assert property (@(posedge clock) disable iff (reset) wb_stb |-> wb_cyc)
    else
    begin
        failure_count++;
        $error("wb_stb high without wb_cyc");
    end

    hold_until_ack: assert property (@(posedge clock) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we)
            && (!wb_we || $stable(wb_dat_w)))
    else
    begin
        failure_count++;
        $error("request dropped or changed before ack");
    end

    next_address: assert property (sequential_fetch)
    else
    begin
        failure_count++;
        $error("fetch after a plain instruction is not at the next address");
    end

    jump_address: assert property (jump_target_fetch)
    else
    begin
        failure_count++;
        $error("fetch after a jump is not at the jump target");
    end

endmodule

bind cpu_top cpu_assertions #(
    .reset_vector (reset_vector)
) i_cpu_assertions (
    .clock    (clock),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
);

/* tb/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

    localparam int clock_period = 40;
    localparam int reset_cycles = 5;
    localparam int program_length = 29;
    // program placed away from address zero to exercise the reset vector
    localparam logic [15:0] program_base = 16'h0020;
    localparam int loop_address = program_base + 28;
    localparam int expected_count = 8;
    // store instruction with three wait states on both bus phases
    localparam int worst_case_cycles = 5 + 2 * 3;
    localparam int watchdog_time =
        (reset_cycles + program_length * worst_case_cycles) * clock_period * 2;

    // operands built by the load pairs at the top of the program
    localparam logic [31:0] r1_value = 32'hABCD_1234;
    localparam logic [31:0] r2_value = 32'h0F00_00F0;

    logic                                clock;
    logic                                reset;
    logic                                wb_cyc;
    logic                                wb_stb;
    logic                                wb_we;
    logic [cpu_pkg::address_width-1:0]   wb_adr;
    logic [cpu_pkg::data_width-1:0]      wb_dat_w;
    logic [cpu_pkg::data_width-1:0]      wb_dat_r;
    logic                                wb_ack;

    logic [cpu_pkg::data_width-1:0]      memory [256];
    logic [cpu_pkg::address_width-1:0]   expected_address [expected_count];
    logic [cpu_pkg::data_width-1:0]      expected_data [expected_count];
    string                               expected_name [expected_count];

    integer seed = 59;
    int     wait_cycles;
    logic   request_pending;
    int     store_count = 0;
    int     loop_fetches = 0;
    int     mismatch_errors = 0;
    int     store_errors = 0;
    int     timeout_errors = 0;

    cpu_top #(
        .reset_vector (program_base)
    ) i_cpu_top (
        .clock    (clock),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #(clock_period / 2) clock = ~clock;

    function automatic logic [31:0] encode(input cpu_pkg::opcode_t op, input int src_a,
        input int src_b, input int dest, input logic [15:0] imm);
        return {imm, 1'b0, dest[2:0], src_b[2:0], src_a[2:0], op};
    endfunction

    task automatic load_program();
        begin
            for (int i = 0; i < 256; i++)
            begin
                memory[i] = 32'hDEAD_0000 + i;
            end
            memory[program_base + 0]  = encode(cpu_pkg::load_low, 0, 0, 1, 16'h1234);
            memory[program_base + 1]  = encode(cpu_pkg::load_high, 0, 0, 1, 16'hABCD);
            // r2 takes its high half first, so load_low has to keep it
            memory[program_base + 2]  = encode(cpu_pkg::load_high, 0, 0, 2, 16'h0F00);
            memory[program_base + 3]  = encode(cpu_pkg::load_low, 0, 0, 2, 16'h00F0);
            memory[program_base + 4]  = encode(cpu_pkg::add, 1, 2, 3, 16'h0);
            memory[program_base + 5]  = encode(cpu_pkg::store, 3, 0, 0, 16'h0080);
            memory[program_base + 6]  = encode(cpu_pkg::sub, 1, 2, 4, 16'h0);
            memory[program_base + 7]  = encode(cpu_pkg::store, 4, 0, 0, 16'h0081);
            memory[program_base + 8]  = encode(cpu_pkg::and_op, 1, 2, 5, 16'h0);
            memory[program_base + 9]  = encode(cpu_pkg::store, 5, 0, 0, 16'h0082);
            memory[program_base + 10] = encode(cpu_pkg::or_op, 1, 2, 6, 16'h0);
            memory[program_base + 11] = encode(cpu_pkg::store, 6, 0, 0, 16'h0083);
            memory[program_base + 12] = encode(cpu_pkg::xor_op, 1, 2, 7, 16'h0);
            memory[program_base + 13] = encode(cpu_pkg::store, 7, 0, 0, 16'h0084);
            // f1 = 1, f2 = (r2 < r1) = 1, f3 = (r1 < r2) = 0
            memory[program_base + 14] = encode(cpu_pkg::set_eq, 1, 1, 1, 16'h0);
            memory[program_base + 15] = encode(cpu_pkg::set_lt, 2, 1, 2, 16'h0);
            memory[program_base + 16] = encode(cpu_pkg::set_lt, 1, 2, 3, 16'h0);
            memory[program_base + 17] = encode(cpu_pkg::branch, 3, 0, 0, program_base + 16'd20);
            memory[program_base + 18] = encode(cpu_pkg::store, 1, 0, 0, 16'h0085);
            memory[program_base + 19] = encode(cpu_pkg::branch, 2, 0, 0, program_base + 16'd21);
            memory[program_base + 20] = encode(cpu_pkg::store, 2, 0, 0, 16'h0086);
            memory[program_base + 21] = encode(cpu_pkg::jump, 0, 0, 0, program_base + 16'd23);
            memory[program_base + 22] = encode(cpu_pkg::store, 3, 0, 0, 16'h0087);
            memory[program_base + 23] = encode(cpu_pkg::branch, 1, 0, 0, program_base + 16'd25);
            memory[program_base + 24] = encode(cpu_pkg::store, 4, 0, 0, 16'h0088);
            memory[program_base + 25] = encode(cpu_pkg::store, 2, 0, 0, 16'h0089);
            // unused opcode aimed at r1, which must stay unchanged
            memory[program_base + 26] = {16'hFFFF, 1'b1, 3'd1, 3'd1, 3'd1, 6'h3F};
            memory[program_base + 27] = encode(cpu_pkg::store, 1, 0, 0, 16'h008A);
            memory[program_base + 28] = encode(cpu_pkg::jump, 0, 0, 0, program_base + 16'd28);
        end
    endtask

    task automatic set_expected(input int index, input string name,
        input logic [15:0] address, input logic [31:0] data);
        begin
            expected_name[index]    = name;
            expected_address[index] = address;
            expected_data[index]    = data;
        end
    endtask

    task automatic check_store(input logic [15:0] address, input logic [31:0] data);
        begin
            if (store_count >= expected_count)
            begin
                store_errors++;
                $display("unexpected extra write of %h to address %h", data, address);
            end
            else
            begin
                if (address !== expected_address[store_count])
                begin
                    mismatch_errors++;
                    $display("mismatch %s address: expected %h, actual %h",
                        expected_name[store_count], expected_address[store_count], address);
                end
                if (data !== expected_data[store_count])
                begin
                    mismatch_errors++;
                    $display("mismatch %s data: expected %h, actual %h",
                        expected_name[store_count], expected_data[store_count], data);
                end
            end
            store_count++;
        end
    endtask

    task automatic finish_run();
        int assertion_errors;
        begin
            assertion_errors = i_cpu_top.i_cpu_assertions.failure_count;
            $display(
                "errors: %0d mismatches, %0d store errors, %0d assertions, %0d timeouts",
                mismatch_errors, store_errors, assertion_errors, timeout_errors);
            if (mismatch_errors + store_errors + assertion_errors + timeout_errors == 0)
                $display("Simulation passed");
            else
                $display("Simulation failed");
            $finish;
        end
    endtask

    // memory slave answering after 0 to 3 wait cycles
    always @(negedge clock)
    begin
        if (reset)
        begin
            wb_ack = 1'b0;
            request_pending = 1'b0;
        end
        else if (wb_ack)
        begin
            wb_ack = 1'b0;
        end
        else if (wb_cyc && wb_stb)
        begin
            if (!request_pending)
            begin
                request_pending = 1'b1;
                wait_cycles = $unsigned($random(seed)) % 4;
            end
            if (wait_cycles == 0)
            begin
                request_pending = 1'b0;
                wb_ack = 1'b1;
                if (wb_we)
                begin
                    memory[wb_adr[7:0]] = wb_dat_w;
                    check_store(wb_adr, wb_dat_w);
                end
                else
                begin
                    wb_dat_r = memory[wb_adr[7:0]];
                    if (wb_adr == loop_address)
                        loop_fetches++;
                end
            end
            else
            begin
                wait_cycles--;
            end
        end
    end

    initial
    begin
        clock = 1'b0;
        reset = 1'b1;
        wb_ack = 1'b0;
        wb_dat_r = '0;
        request_pending = 1'b0;
        wait_cycles = 0;
        load_program();
        set_expected(0, "add", 16'h0080, r1_value + r2_value);
        set_expected(1, "sub", 16'h0081, r1_value - r2_value);
        set_expected(2, "and_op", 16'h0082, r1_value & r2_value);
        set_expected(3, "or_op", 16'h0083, r1_value | r2_value);
        set_expected(4, "xor_op", 16'h0084, r1_value ^ r2_value);
        set_expected(5, "branch not taken", 16'h0085, r1_value);
        set_expected(6, "taken branch target", 16'h0089, r2_value);
        set_expected(7, "unknown opcode", 16'h008A, r1_value);
        repeat (reset_cycles) @(negedge clock);
        reset = 1'b0;
        // a second fetch of the self loop means the jump was taken
        wait (loop_fetches >= 2);
        repeat (4) @(negedge clock);
        if (store_count < expected_count)
        begin
            store_errors += expected_count - store_count;
            $display("missing store: only %0d of %0d stores were seen",
                store_count, expected_count);
        end
        finish_run();
    end

    initial
    begin
        #(watchdog_time);
        timeout_errors++;
        $display("timeout: program did not reach its final loop within %0d ns", watchdog_time);
        finish_run();
    end

endmodule

/* sources.f */
logic/cpu_pkg.sv
logic/register_file.sv
logic/flag_file.sv
logic/alu.sv
logic/cpu_control.sv
logic/cpu_top.sv
tb/cpu_assertions.sv
tb/cpu_tb.sv
